// ==== rtl/lc_pkg.sv ====
`default_nettype none

package lc_pkg;

	// Bus word geometry
	localparam int ADDR_WIDTH = 8;
	localparam int DATA_WIDTH = 32;
	localparam int FUNC_WIDTH = 4;

	// Register entry is 24 bits, index rides in the top byte of a bus word
	localparam int RF_DATA_WIDTH = 24;
	localparam int RF_IDX_WIDTH = DATA_WIDTH - RF_DATA_WIDTH;

	localparam int MEM_ADDR_WIDTH = 8;

	// Function codes from the low address bits
	localparam logic [FUNC_WIDTH-1:0] FUNC_RF_WRITE = 4'd0;
	localparam logic [FUNC_WIDTH-1:0] FUNC_MEM_WRITE = 4'd1;
	localparam logic [FUNC_WIDTH-1:0] FUNC_MEM_READ = 4'd2;
	localparam logic [FUNC_WIDTH-1:0] FUNC_RF_READ = 4'd3;

	// One queued receive word
	typedef struct packed {
		logic [DATA_WIDTH-1:0] data;
		logic [FUNC_WIDTH-1:0] func;
		logic last;
		logic fail;
	} rx_word_t;

	// One word handed to the transmit side
	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
		logic [DATA_WIDTH-1:0] data;
		logic pend;
		logic prio;
	} tx_word_t;

	// Register write with independent half loads
	typedef struct packed {
		logic [RF_IDX_WIDTH-1:0] idx;
		logic [RF_DATA_WIDTH-1:0] data;
		logic lsb_load;
		logic msb_load;
	} rf_wr_t;

endpackage

`default_nettype wire

// ==== rtl/lc_rx_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module lc_rx_queue #(
	parameter int BUF_SIZE = 4
) (
	input wire logic CLK,
	input wire logic resetn_local,
	input wire logic rx_req,
	input wire logic rx_fail,
	input wire logic [lc_pkg::ADDR_WIDTH-1:0] rx_addr,
	input wire logic [lc_pkg::DATA_WIDTH-1:0] rx_data,
	input wire logic rx_pend,
	input wire logic pop,
	output logic rx_ack,
	output logic valid,
	output lc_pkg::rx_word_t word
);
	import lc_pkg::*;

	localparam int PTR_W = (BUF_SIZE > 1) ? $clog2(BUF_SIZE) : 1;
	localparam int CNT_W = $clog2(BUF_SIZE + 1);

	rx_word_t buffer [BUF_SIZE];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	logic take;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(BUF_SIZE - 1)) ? '0 : p + 1'b1;
	endfunction

	// Only acknowledge when a slot is free, full queue stalls the bus
	assign push = !rx_ack && (rx_req || rx_fail) && (count != CNT_W'(BUF_SIZE));
	assign valid = (count != '0);
	assign take = pop && valid;
	assign word = buffer[rd_ptr];

	always_ff @(posedge CLK or negedge resetn_local)
	begin
		if (!resetn_local)
		begin
			rx_ack <= 1'b0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			// Four-phase: drop ack once both req and fail are gone
			if (push)
				rx_ack <= 1'b1;
			else if (rx_ack && !rx_req && !rx_fail)
				rx_ack <= 1'b0;
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (take)
				rd_ptr <= next_ptr(rd_ptr);
			if (push && !take)
				count <= count + 1'b1;
			else if (take && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (push)
		begin
			buffer[wr_ptr] <= '{
				data: rx_data,
				func: rx_addr[FUNC_WIDTH-1:0],
				last: !rx_pend,
				fail: rx_fail
			};
		end
	end

endmodule

`default_nettype wire

// ==== rtl/lc_cmd_exec.sv ====
`timescale 1ns/100ps
`default_nettype none

module lc_cmd_exec #(
	parameter int RF_NUM = 8,
	parameter logic [lc_pkg::ADDR_WIDTH-1:0] INT_REPLY_ADDR = 8'hF0
) (
	input wire logic CLK,
	input wire logic resetn_local,
	input wire logic valid,
	input wire lc_pkg::rx_word_t word,
	input wire logic tx_busy,
	input wire logic [lc_pkg::RF_DATA_WIDTH-1:0] rf_rdata,
	input wire logic mem_ack,
	input wire logic [lc_pkg::DATA_WIDTH-1:0] mem_rdata,
	input wire logic interrupt,
	output logic pop,
	output logic tx_send,
	output lc_pkg::tx_word_t tx_word,
	output lc_pkg::rf_wr_t rf_wr,
	output logic rf_we,
	output logic [lc_pkg::RF_IDX_WIDTH-1:0] rf_idx,
	output logic mem_req,
	output logic mem_write,
	output logic [lc_pkg::MEM_ADDR_WIDTH-1:0] mem_addr,
	output logic [lc_pkg::DATA_WIDTH-1:0] mem_wdata,
	output logic clr_int
);
	import lc_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_GATHER,
		ST_MEM,
		ST_REPLY,
		ST_INT,
		ST_DRAIN
	} state_t;

	state_t state;
	logic [FUNC_WIDTH-1:0] func;
	logic [1:0] arg_cnt;
	logic msg_last;
	logic have_word;
	logic [ADDR_WIDTH-1:0] reply_addr;
	logic [4:0] rd_left;
	logic [DATA_WIDTH-1:0] mem_word;
	logic in_int;
	logic rf_reply;
	logic [4:0] count_in;

	// Words are consumed in the cycle they are looked at
	assign pop = valid && (state == ST_GATHER || state == ST_DRAIN);
	assign in_int = (state == ST_INT);
	assign rf_reply = in_int || (func == FUNC_RF_READ);
	assign tx_send = have_word && !tx_busy && (state == ST_REPLY || in_int);
	assign tx_word = '{
		addr: in_int ? INT_REPLY_ADDR : reply_addr,
		data: rf_reply ? {rf_idx, rf_rdata} : mem_word,
		pend: !in_int && (func == FUNC_MEM_READ) && (rd_left != 5'd0),
		prio: in_int
	};

	// Read count limited to 1..16
	always_comb
	begin
		count_in = word.data[4:0];
		if (word.data[4:0] == 5'd0)
			count_in = 5'd1;
		else if (word.data[4:0] > 5'd16)
			count_in = 5'd16;
	end

	always_ff @(posedge CLK or negedge resetn_local)
	begin
		if (!resetn_local)
		begin
			state <= ST_IDLE;
			func <= '0;
			arg_cnt <= '0;
			msg_last <= 1'b0;
			have_word <= 1'b0;
			reply_addr <= '0;
			rd_left <= '0;
			mem_word <= '0;
			rf_wr <= '0;
			rf_we <= 1'b0;
			rf_idx <= '0;
			mem_req <= 1'b0;
			mem_write <= 1'b0;
			mem_addr <= '0;
			mem_wdata <= '0;
			clr_int <= 1'b0;
		end
		else
		begin
			rf_we <= 1'b0;
			case (state)
			ST_IDLE:
			begin
				// Interrupt only between messages, reply carries entry 0
				if (interrupt)
				begin
					clr_int <= 1'b1;
					rf_idx <= '0;
					have_word <= 1'b1;
					state <= ST_INT;
				end
				else if (valid)
				begin
					func <= word.func;
					arg_cnt <= '0;
					state <= (word.func > FUNC_RF_READ) ? ST_DRAIN : ST_GATHER;
				end
			end
			ST_GATHER:
			begin
				if (valid && word.fail)
					state <= word.last ? ST_IDLE : ST_DRAIN;
				else if (valid)
				begin
					msg_last <= word.last;
					arg_cnt <= arg_cnt + 2'd1;
					case (func)
					FUNC_RF_WRITE:
					begin
						rf_wr <= '{
							idx: word.data[DATA_WIDTH-1 -: RF_IDX_WIDTH],
							data: word.data[RF_DATA_WIDTH-1:0],
							lsb_load: 1'b1,
							msb_load: 1'b1
						};
						rf_we <= (word.data[DATA_WIDTH-1 -: RF_IDX_WIDTH] < RF_NUM);
						if (word.last)
							state <= ST_IDLE;
					end
					FUNC_MEM_WRITE:
					begin
						if (arg_cnt == 2'd0)
						begin
							mem_addr <= word.data[MEM_ADDR_WIDTH-1:0];
							if (word.last)
								state <= ST_IDLE;
						end
						else
						begin
							// Hold arg_cnt so every later word is data
							arg_cnt <= arg_cnt;
							mem_wdata <= word.data;
							mem_write <= 1'b1;
							mem_req <= 1'b1;
							state <= ST_MEM;
						end
					end
					FUNC_MEM_READ:
					begin
						if (arg_cnt == 2'd0)
							reply_addr <= word.data[ADDR_WIDTH-1:0];
						else if (arg_cnt == 2'd1)
							mem_addr <= word.data[MEM_ADDR_WIDTH-1:0];
						else
						begin
							rd_left <= count_in;
							mem_write <= 1'b0;
							mem_req <= 1'b1;
							state <= ST_MEM;
						end
						if (word.last && arg_cnt != 2'd2)
							state <= ST_IDLE;
					end
					FUNC_RF_READ:
					begin
						if (arg_cnt == 2'd0)
						begin
							reply_addr <= word.data[ADDR_WIDTH-1:0];
							if (word.last)
								state <= ST_IDLE;
						end
						else
						begin
							rf_idx <= word.data[RF_IDX_WIDTH-1:0];
							have_word <= 1'b1;
							state <= ST_REPLY;
						end
					end
					default:
						state <= ST_DRAIN;
					endcase
				end
			end
			ST_MEM:
			begin
				if (mem_ack)
				begin
					mem_req <= 1'b0;
					mem_addr <= mem_addr + 1'b1;
					if (mem_write)
						state <= msg_last ? ST_IDLE : ST_GATHER;
					else
					begin
						mem_word <= mem_rdata;
						rd_left <= rd_left - 5'd1;
						have_word <= 1'b1;
						state <= ST_REPLY;
					end
				end
			end
			ST_REPLY:
			begin
				if (tx_send)
				begin
					have_word <= 1'b0;
					if (func == FUNC_MEM_READ && rd_left != 5'd0)
					begin
						mem_req <= 1'b1;
						state <= ST_MEM;
					end
					else
						state <= msg_last ? ST_IDLE : ST_DRAIN;
				end
			end
			ST_INT:
			begin
				if (tx_send)
					have_word <= 1'b0;
				// Keep clr_int up until the source lets go
				if (!have_word && !interrupt)
				begin
					clr_int <= 1'b0;
					state <= ST_IDLE;
				end
			end
			ST_DRAIN:
			begin
				if (valid && word.last)
					state <= ST_IDLE;
			end
			default:
				state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/lc_tx_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module lc_tx_engine (
	input wire logic CLK,
	input wire logic resetn_local,
	input wire logic send,
	input wire lc_pkg::tx_word_t word,
	input wire logic tx_ack,
	input wire logic tx_succ,
	input wire logic tx_fail,
	output logic busy,
	output logic tx_req,
	output logic [lc_pkg::ADDR_WIDTH-1:0] tx_addr,
	output logic [lc_pkg::DATA_WIDTH-1:0] tx_data,
	output logic tx_pend,
	output logic tx_priority,
	output logic tx_resp_ack
);

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_WORD,
		TX_RELEASE,
		TX_RESP,
		TX_RESP_DONE
	} tx_state_t;

	tx_state_t state;

	assign busy = (state != TX_IDLE);

	always_ff @(posedge CLK or negedge resetn_local)
	begin
		if (!resetn_local)
		begin
			state <= TX_IDLE;
			tx_req <= 1'b0;
			tx_addr <= '0;
			tx_data <= '0;
			tx_pend <= 1'b0;
			tx_priority <= 1'b0;
			tx_resp_ack <= 1'b0;
		end
		else
		begin
			case (state)
			TX_IDLE:
			begin
				if (send)
				begin
					tx_addr <= word.addr;
					tx_data <= word.data;
					tx_pend <= word.pend;
					tx_priority <= word.prio;
					tx_req <= 1'b1;
					state <= TX_WORD;
				end
			end
			TX_WORD:
			begin
				if (tx_ack)
				begin
					tx_req <= 1'b0;
					state <= TX_RELEASE;
				end
			end
			// Wait for ack to fall, then either next word or the result
			TX_RELEASE:
			begin
				if (!tx_ack)
					state <= tx_pend ? TX_IDLE : TX_RESP;
			end
			TX_RESP:
			begin
				if (tx_succ || tx_fail)
				begin
					tx_resp_ack <= 1'b1;
					state <= TX_RESP_DONE;
				end
			end
			TX_RESP_DONE:
			begin
				if (!tx_succ && !tx_fail)
				begin
					tx_resp_ack <= 1'b0;
					state <= TX_IDLE;
				end
			end
			default:
				state <= TX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/lc_reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module lc_reg_file #(
	parameter int RF_NUM = 8
) (
	input wire logic CLK,
	input wire logic resetn_local,
	input wire logic we,
	input wire lc_pkg::rf_wr_t wr,
	input wire logic [lc_pkg::RF_IDX_WIDTH-1:0] idx,
	output logic [lc_pkg::RF_DATA_WIDTH-1:0] rdata
);
	import lc_pkg::*;

	localparam int HALF = RF_DATA_WIDTH / 2;
	localparam int IDX_W = (RF_NUM > 1) ? $clog2(RF_NUM) : 1;

	logic [RF_DATA_WIDTH-1:0] entry [RF_NUM];

	always_ff @(posedge CLK or negedge resetn_local)
	begin
		if (!resetn_local)
		begin
			for (int i = 0; i < RF_NUM; i++)
				entry[i] <= '0;
		end
		else if (we && wr.idx < RF_NUM)
		begin
			// Lower and upper halves load on their own
			if (wr.lsb_load)
				entry[wr.idx[IDX_W-1:0]][HALF-1:0] <= wr.data[HALF-1:0];
			if (wr.msb_load)
				entry[wr.idx[IDX_W-1:0]][RF_DATA_WIDTH-1:HALF] <= wr.data[RF_DATA_WIDTH-1:HALF];
		end
	end

	assign rdata = (idx < RF_NUM) ? entry[idx[IDX_W-1:0]] : '0;

endmodule

`default_nettype wire

// ==== rtl/lc_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module lc_mem #(
	parameter int MEM_DEPTH = 256,
	parameter int MEM_LATENCY = 2
) (
	input wire logic CLK,
	input wire logic resetn_local,
	input wire logic req,
	input wire logic write,
	input wire logic [lc_pkg::MEM_ADDR_WIDTH-1:0] addr,
	input wire logic [lc_pkg::DATA_WIDTH-1:0] wdata,
	output logic ack,
	output logic [lc_pkg::DATA_WIDTH-1:0] rdata
);
	import lc_pkg::*;

	localparam int CNT_W = $clog2(MEM_LATENCY + 1);
	localparam int IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

	logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];
	logic [CNT_W-1:0] wait_cnt;
	logic done;

	// Access completes MEM_LATENCY cycles after req rises
	assign done = req && !ack && (wait_cnt == CNT_W'(MEM_LATENCY - 1));

	always_ff @(posedge CLK or negedge resetn_local)
	begin
		if (!resetn_local)
		begin
			ack <= 1'b0;
			wait_cnt <= '0;
		end
		else
		begin
			ack <= done;
			if (!req || ack || done)
				wait_cnt <= '0;
			else
				wait_cnt <= wait_cnt + 1'b1;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (done && write)
			mem[addr[IDX_W-1:0]] <= wdata;
		else if (done)
			rdata <= mem[addr[IDX_W-1:0]];
	end

endmodule

`default_nettype wire

// ==== rtl/lc_layer_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module lc_layer_top #(
	parameter int BUF_SIZE = 4,
	parameter int RF_NUM = 8,
	parameter int MEM_DEPTH = 256,
	parameter int MEM_LATENCY = 2,
	parameter logic [lc_pkg::ADDR_WIDTH-1:0] INT_REPLY_ADDR = 8'hF0
) (
	input wire logic CLK,
	input wire logic resetn_local,
	// Receive side
	input wire logic rx_req,
	input wire logic [lc_pkg::ADDR_WIDTH-1:0] rx_addr,
	input wire logic [lc_pkg::DATA_WIDTH-1:0] rx_data,
	input wire logic rx_pend,
	input wire logic rx_fail,
	output logic rx_ack,
	// Transmit side
	output logic tx_req,
	output logic [lc_pkg::ADDR_WIDTH-1:0] tx_addr,
	output logic [lc_pkg::DATA_WIDTH-1:0] tx_data,
	output logic tx_pend,
	output logic tx_priority,
	input wire logic tx_ack,
	input wire logic tx_succ,
	input wire logic tx_fail,
	output logic tx_resp_ack,
	input wire logic interrupt,
	output logic clr_int
);
	import lc_pkg::*;

	rx_word_t rx_word;
	logic rx_valid;
	logic rx_pop;
	tx_word_t tx_word;
	logic tx_send;
	logic tx_busy;
	rf_wr_t rf_wr;
	logic rf_we;
	logic [RF_IDX_WIDTH-1:0] rf_idx;
	logic [RF_DATA_WIDTH-1:0] rf_rdata;
	logic mem_req;
	logic mem_write;
	logic mem_ack;
	logic [MEM_ADDR_WIDTH-1:0] mem_addr;
	logic [DATA_WIDTH-1:0] mem_wdata;
	logic [DATA_WIDTH-1:0] mem_rdata;

	lc_rx_queue #(.BUF_SIZE(BUF_SIZE)) lc_rx_queue_inst (
		.CLK(CLK), .resetn_local(resetn_local),
		.rx_req(rx_req), .rx_fail(rx_fail), .rx_addr(rx_addr), .rx_data(rx_data),
		.rx_pend(rx_pend), .pop(rx_pop), .rx_ack(rx_ack), .valid(rx_valid), .word(rx_word)
	);

	lc_cmd_exec #(.RF_NUM(RF_NUM), .INT_REPLY_ADDR(INT_REPLY_ADDR)) lc_cmd_exec_inst (
		.CLK(CLK), .resetn_local(resetn_local),
		.valid(rx_valid), .word(rx_word), .tx_busy(tx_busy), .rf_rdata(rf_rdata),
		.mem_ack(mem_ack), .mem_rdata(mem_rdata), .interrupt(interrupt),
		.pop(rx_pop), .tx_send(tx_send), .tx_word(tx_word), .rf_wr(rf_wr), .rf_we(rf_we),
		.rf_idx(rf_idx), .mem_req(mem_req), .mem_write(mem_write), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .clr_int(clr_int)
	);

	lc_tx_engine lc_tx_engine_inst (
		.CLK(CLK), .resetn_local(resetn_local),
		.send(tx_send), .word(tx_word), .tx_ack(tx_ack), .tx_succ(tx_succ),
		.tx_fail(tx_fail), .busy(tx_busy), .tx_req(tx_req), .tx_addr(tx_addr),
		.tx_data(tx_data), .tx_pend(tx_pend), .tx_priority(tx_priority),
		.tx_resp_ack(tx_resp_ack)
	);

	lc_reg_file #(.RF_NUM(RF_NUM)) lc_reg_file_inst (
		.CLK(CLK), .resetn_local(resetn_local),
		.we(rf_we), .wr(rf_wr), .idx(rf_idx), .rdata(rf_rdata)
	);

	lc_mem #(.MEM_DEPTH(MEM_DEPTH), .MEM_LATENCY(MEM_LATENCY)) lc_mem_inst (
		.CLK(CLK), .resetn_local(resetn_local),
		.req(mem_req), .write(mem_write), .addr(mem_addr), .wdata(mem_wdata),
		.ack(mem_ack), .rdata(mem_rdata)
	);

endmodule

`default_nettype wire

// ==== tb/tb_lc_layer.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_lc_layer;
	import lc_pkg::*;

	localparam int BUF_SIZE = 4;
	localparam int RF_NUM = 8;
	localparam int MEM_DEPTH = 256;
	localparam int MEM_LATENCY = 2;
	localparam logic [ADDR_WIDTH-1:0] INT_REPLY_ADDR = 8'hF0;
	localparam int RF_IDX_BITS = $clog2(RF_NUM);
	localparam logic [3:0] NODE_ID = 4'hA;
	localparam int RESET_CYCLES = 10;
	// 40 bus messages across the six tests, 400 cycles allowed for each
	localparam int NUM_MSGS = 40;
	localparam int MSG_BOUND = 400;

	logic CLK = 1'b0;
	logic resetn_local;
	logic rx_req;
	logic [ADDR_WIDTH-1:0] rx_addr;
	logic [DATA_WIDTH-1:0] rx_data;
	logic rx_pend;
	logic rx_fail;
	logic rx_ack;
	logic tx_req;
	logic [ADDR_WIDTH-1:0] tx_addr;
	logic [DATA_WIDTH-1:0] tx_data;
	logic tx_pend;
	logic tx_priority;
	logic tx_ack;
	logic tx_succ;
	logic tx_fail;
	logic tx_resp_ack;
	logic interrupt;
	logic clr_int;

	integer seed = 32'h93e4_c011;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int errs_at_start = 0;
	int words_sent = 0;
	int msgs_done = 0;
	logic tx_hold = 1'b0;
	logic [ADDR_WIDTH-1:0] mem_reply;
	logic [DATA_WIDTH-1:0] msg_q[$];
	tx_word_t rep_q[$];

	// Reference model of the node state
	logic [RF_DATA_WIDTH-1:0] model_rf [RF_NUM];
	logic [DATA_WIDTH-1:0] model_mem [MEM_DEPTH];

	always #20 CLK = ~CLK;

	lc_layer_top #(
		.BUF_SIZE(BUF_SIZE),
		.RF_NUM(RF_NUM),
		.MEM_DEPTH(MEM_DEPTH),
		.MEM_LATENCY(MEM_LATENCY),
		.INT_REPLY_ADDR(INT_REPLY_ADDR)
	) lc_layer_top_inst (
		.CLK(CLK),
		.resetn_local(resetn_local),
		.rx_req(rx_req),
		.rx_addr(rx_addr),
		.rx_data(rx_data),
		.rx_pend(rx_pend),
		.rx_fail(rx_fail),
		.rx_ack(rx_ack),
		.tx_req(tx_req),
		.tx_addr(tx_addr),
		.tx_data(tx_data),
		.tx_pend(tx_pend),
		.tx_priority(tx_priority),
		.tx_ack(tx_ack),
		.tx_succ(tx_succ),
		.tx_fail(tx_fail),
		.tx_resp_ack(tx_resp_ack),
		.interrupt(interrupt),
		.clr_int(clr_int)
	);

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == errs_at_start)
			$display("Test %0d %s: ok", tests_run, name);
		else
			$display("Test %0d %s: %0d failed checks", tests_run, name, errors - errs_at_start);
		errs_at_start = errors;
	endtask

	// One four-phase word on the receive link
	task automatic send_word(input logic [3:0] func, input logic [31:0] data,
		input logic pend, input logic fail);
		@(posedge CLK);
		rx_req <= 1'b1;
		rx_fail <= fail;
		rx_addr <= {NODE_ID, func};
		rx_data <= data;
		rx_pend <= pend;
		do
			@(posedge CLK);
		while (!rx_ack);
		rx_req <= 1'b0;
		rx_fail <= 1'b0;
		do
			@(posedge CLK);
		while (rx_ack);
		words_sent++;
	endtask

	task automatic send_msg(input logic [3:0] func, input int fail_at);
		for (int i = 0; i < msg_q.size(); i++)
			send_word(func, msg_q[i], i != msg_q.size() - 1, i == fail_at);
	endtask

	task automatic wait_msgs(input int n);
		while (msgs_done < n)
			@(posedge CLK);
	endtask

	task automatic write_regs(input int n, input int fail_at);
		logic [31:0] w;
		msg_q.delete();
		for (int i = 0; i < n; i++)
		begin
			w = {8'({$random(seed)} % RF_NUM), 24'($random(seed))};
			msg_q.push_back(w);
			// Words ahead of a failed one still count
			if (fail_at < 0 || i < fail_at)
				model_rf[w[RF_DATA_WIDTH +: RF_IDX_BITS]] = w[RF_DATA_WIDTH-1:0];
		end
		send_msg(FUNC_RF_WRITE, fail_at);
	endtask

	task automatic read_reg(input logic [RF_IDX_BITS-1:0] idx);
		logic [7:0] reply;
		int base;
		tx_word_t w;
		reply = 8'($random(seed));
		base = msgs_done;
		msg_q.delete();
		msg_q.push_back(32'(reply));
		msg_q.push_back(32'(idx));
		send_msg(FUNC_RF_READ, -1);
		wait_msgs(base + 1);
		check_val("rf reply words", rep_q.size(), 1);
		if (rep_q.size() != 0)
		begin
			w = rep_q.pop_front();
			check_val("tx_addr", 32'(w.addr), 32'(reply));
			check_val("tx_data", w.data, {8'(idx), model_rf[idx]});
			check_val("tx_pend", 32'(w.pend), 0);
			check_val("tx_priority", 32'(w.prio), 0);
		end
		rep_q.delete();
	endtask

	task automatic read_all();
		for (int i = 0; i < RF_NUM; i++)
			read_reg(RF_IDX_BITS'(i));
	endtask

	task automatic send_mem_read(input logic [7:0] start, input int count);
		mem_reply = 8'($random(seed));
		msg_q.delete();
		msg_q.push_back(32'(mem_reply));
		msg_q.push_back(32'(start));
		msg_q.push_back(32'(count));
		send_msg(FUNC_MEM_READ, -1);
	endtask

	task automatic check_mem_reply(input logic [7:0] start, input int count);
		tx_word_t w;
		check_val("mem reply words", rep_q.size(), count);
		for (int i = 0; i < count && rep_q.size() != 0; i++)
		begin
			w = rep_q.pop_front();
			check_val("tx_addr", 32'(w.addr), 32'(mem_reply));
			check_val("tx_data", w.data, model_mem[8'(start + i)]);
			check_val("tx_pend", 32'(w.pend), 32'(i != count - 1));
			check_val("tx_priority", 32'(w.prio), 0);
		end
		rep_q.delete();
	endtask

	// Bus controller side of the transmit and response links
	initial
	begin
		tx_word_t w;
		tx_ack <= 1'b0;
		tx_succ <= 1'b0;
		tx_fail <= 1'b0;
		forever
		begin
			@(posedge CLK);
			if (tx_req && !tx_hold)
			begin
				repeat ({$random(seed)} % 4)
					@(posedge CLK);
				w.addr = tx_addr;
				w.data = tx_data;
				w.pend = tx_pend;
				w.prio = tx_priority;
				rep_q.push_back(w);
				tx_ack <= 1'b1;
				do
					@(posedge CLK);
				while (tx_req);
				tx_ack <= 1'b0;
				if (!w.pend)
				begin
					repeat ({$random(seed)} % 4)
						@(posedge CLK);
					if (1'($random(seed)))
						tx_fail <= 1'b1;
					else
						tx_succ <= 1'b1;
					do
						@(posedge CLK);
					while (!tx_resp_ack);
					tx_succ <= 1'b0;
					tx_fail <= 1'b0;
					do
						@(posedge CLK);
					while (tx_resp_ack);
					msgs_done++;
				end
			end
		end
	end

	initial
	begin
		repeat (RESET_CYCLES + NUM_MSGS * MSG_BOUND)
			@(posedge CLK);
		$display("Watchdog expired: the DUT stopped answering on the bus");
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial
	begin
		logic [7:0] blk_start;
		logic [7:0] rd_start;
		int count;
		int base;
		int sent_before;
		tx_word_t w;
		resetn_local <= 1'b0;
		rx_req <= 1'b0;
		rx_addr <= '0;
		rx_data <= '0;
		rx_pend <= 1'b0;
		rx_fail <= 1'b0;
		interrupt <= 1'b0;
		for (int i = 0; i < RF_NUM; i++)
			model_rf[i] = '0;
		repeat (RESET_CYCLES)
			@(posedge CLK);
		resetn_local <= 1'b1;
		@(posedge CLK);

		write_regs(12, -1);
		read_all();
		end_test("register write and read");

		// 16-word block, later reads stay inside it
		blk_start = 8'($random(seed));
		msg_q.delete();
		msg_q.push_back(32'(blk_start));
		for (int i = 0; i < 16; i++)
		begin
			msg_q.push_back($random(seed));
			model_mem[8'(blk_start + i)] = msg_q[i + 1];
		end
		send_msg(FUNC_MEM_WRITE, -1);
		count = 1 + {$random(seed)} % 16;
		rd_start = 8'(blk_start + {$random(seed)} % (17 - count));
		base = msgs_done;
		send_mem_read(rd_start, count);
		wait_msgs(base + 1);
		check_mem_reply(rd_start, count);
		end_test("memory block write and read");

		// A read of two or more words stalls the executor on the held link
		tx_hold <= 1'b1;
		count = 2 + {$random(seed)} % 15;
		rd_start = 8'(blk_start + {$random(seed)} % (17 - count));
		base = msgs_done;
		send_mem_read(rd_start, count);
		sent_before = words_sent;
		fork
			write_regs(BUF_SIZE + 3, -1);
			begin
				while (words_sent < sent_before + BUF_SIZE)
					@(posedge CLK);
				repeat (8)
				begin
					@(posedge CLK);
					check_val("rx_ack", 32'(rx_ack), 0);
				end
				tx_hold <= 1'b0;
			end
		join
		wait_msgs(base + 1);
		check_mem_reply(rd_start, count);
		read_all();
		end_test("receive back-pressure");

		write_regs(3, 1);
		read_all();
		end_test("failed message");

		@(posedge CLK);
		check_val("clr_int", 32'(clr_int), 0);
		base = msgs_done;
		interrupt <= 1'b1;
		wait_msgs(base + 1);
		check_val("int reply words", rep_q.size(), 1);
		if (rep_q.size() != 0)
		begin
			w = rep_q.pop_front();
			check_val("tx_addr", 32'(w.addr), 32'(INT_REPLY_ADDR));
			check_val("tx_data", w.data, {8'h00, model_rf[0]});
			check_val("tx_pend", 32'(w.pend), 0);
			check_val("tx_priority", 32'(w.prio), 1);
		end
		rep_q.delete();
		check_val("clr_int", 32'(clr_int), 1);
		interrupt <= 1'b0;
		while (clr_int)
			@(posedge CLK);
		end_test("interrupt");

		// Words shaped like register writes must not touch the entries
		msg_q.delete();
		for (int i = 0; i < 3; i++)
			msg_q.push_back({8'({$random(seed)} % RF_NUM), 24'($random(seed))});
		send_msg(4'(4 + {$random(seed)} % 12), -1);
		read_all();
		end_test("unknown function");

		$display("Tests run: %0d, checks: %0d, failed checks: %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== lc_layer_top.f ====
rtl/lc_pkg.sv
rtl/lc_rx_queue.sv
rtl/lc_cmd_exec.sv
rtl/lc_tx_engine.sv
rtl/lc_reg_file.sv
rtl/lc_mem.sv
rtl/lc_layer_top.sv
tb/tb_lc_layer.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP := tb_lc_layer
RTL_TOP := lc_layer_top
FILELIST := lc_layer_top.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS := --binary --timing --assert -j 0
OBJ_DIR := obj_dir
PASS_MSG := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
